/* source/hackPkg.sv */
/*
 * Shared HACK definitions: word type, instruction field positions,
 * memory map addresses, comp and jump encodings
 */
`default_nettype none
package hackPkg;

	typedef logic [15:0] hackWord; // data and instruction word

	localparam int unsigned instrMsb = 15; // 1 = C-instruction
	localparam int unsigned compMsb = 12; // a bit
	localparam int unsigned compLsb = 6; // c6
	localparam int unsigned destABit = 5;
	localparam int unsigned destDBit = 4;
	localparam int unsigned destMBit = 3;
	localparam int unsigned jumpMsb = 2;
	localparam int unsigned jumpLsb = 0;

	localparam int unsigned ramWords = 3584; // 0-3583
	localparam int unsigned ramAddrBits = 12;
	localparam int unsigned progWords = 256;
	localparam int unsigned progAddrBits = 8;
	localparam hackWord ledAddr = 16'd4096;
	localparam hackWord butAddr = 16'd4097;
	localparam hackWord debugAddr = 16'd4107;

	// a bit followed by c1..c6 (zx nx zy ny f no)
	typedef enum logic [6:0] {
		compZero = 7'b0101010, compOne = 7'b0111111, compMinusOne = 7'b0111010,
		compD = 7'b0001100, compA = 7'b0110000, compNotD = 7'b0001101,
		compNotA = 7'b0110001, compNegD = 7'b0001111, compNegA = 7'b0110011,
		compDPlus1 = 7'b0011111, compAPlus1 = 7'b0110111, compDMinus1 = 7'b0001110,
		compAMinus1 = 7'b0110010, compDPlusA = 7'b0000010, compDMinusA = 7'b0010011,
		compAMinusD = 7'b0000111, compDAndA = 7'b0000000, compDOrA = 7'b0010101,
		compM = 7'b1110000, compNotM = 7'b1110001, compNegM = 7'b1110011,
		compMPlus1 = 7'b1110111, compMMinus1 = 7'b1110010, compDPlusM = 7'b1000010,
		compDMinusM = 7'b1010011, compMMinusD = 7'b1000111, compDAndM = 7'b1000000,
		compDOrM = 7'b1010101
	} compCode;

	typedef enum logic [2:0] {
		jmpNever = 3'b000, jmpGt = 3'b001, jmpEq = 3'b010, jmpGe = 3'b011,
		jmpLt = 3'b100, jmpNe = 3'b101, jmpLe = 3'b110, jmpAlways = 3'b111
	} jumpCond;

endpackage
`default_nettype wire

/* source/hackAlu.sv */
/*
 * HACK ALU: zero/negate inputs, add or and, negate output,
 * zero and negative flags
 */
`timescale 1ns/100ps
`default_nettype none
module hackAlu import hackPkg::*; (
	input  hackWord x,      // D register
	input  hackWord y,      // A register or M
	input  logic    zx,     // zero x
	input  logic    nx,     // negate x
	input  logic    zy,     // zero y
	input  logic    ny,     // negate y
	input  logic    f,      // 1 = x+y, 0 = x&y
	input  logic    no,     // negate out
	output hackWord result,
	output logic    zr,     // result == 0
	output logic    ng      // result[15]
);

	hackWord xZero, yZero; // after zx/zy
	hackWord xIn, yIn;     // after nx/ny
	hackWord fOut;         // add or and

	assign xZero = zx ? '0 : x;
	assign yZero = zy ? '0 : y;
	assign xIn   = nx ? ~xZero : xZero; // bitwise not
	assign yIn   = ny ? ~yZero : yZero;

	// Two's complement add wraps at 16 bits
	assign fOut   = f ? (xIn + yIn) : (xIn & yIn);
	assign result = no ? ~fOut : fOut;

	assign zr = (result == '0);
	assign ng = result[15]; // sign bit

endmodule
`default_nettype wire

/* source/hackControl.sv */
/*
 * HACK instruction decoder: A/C split, dest strobes,
 * ALU control bits, memory write and jump decision
 */
`timescale 1ns/100ps
`default_nettype none
module hackControl import hackPkg::*; (
	input  hackWord instruction, // current ROM word
	input  logic    zr,          // ALU result == 0
	input  logic    ng,          // ALU result < 0
	output logic    loadA,
	output logic    loadD,
	output logic    selAFromAlu, // 0 = A takes instruction
	output logic    selYFromM,   // 1 = y from RAM/IO
	output logic    zx,
	output logic    nx,
	output logic    zy,
	output logic    ny,
	output logic    f,
	output logic    no,
	output logic    writeM,
	output logic    takeJump
);

	logic    isC;      // C-instruction
	compCode comp;     // a + c1..c6
	jumpCond jump;     // j1..j3
	logic    condMet;  // jump condition vs flags

	assign isC  = instruction[instrMsb];
	assign comp = compCode'(instruction[compMsb:compLsb]);
	assign jump = jumpCond'(instruction[jumpMsb:jumpLsb]);

	// Field decode, everything except loadA held low for A-instructions
	always_comb begin
		loadA       = 1'b1; // @value
		loadD       = 1'b0;
		selAFromAlu = 1'b0;
		selYFromM   = 1'b0;
		zx          = 1'b0;
		nx          = 1'b0;
		zy          = 1'b0;
		ny          = 1'b0;
		f           = 1'b0;
		no          = 1'b0;
		writeM      = 1'b0;
		if (isC) begin
			loadA       = instruction[destABit];
			loadD       = instruction[destDBit];
			writeM      = instruction[destMBit];
			selAFromAlu = 1'b1; // A=comp
			selYFromM   = comp[6]; // a bit
			zx          = comp[5];
			nx          = comp[4];
			zy          = comp[3];
			ny          = comp[2];
			f           = comp[1]; // 1 = add, 0 = and
			no          = comp[0];
		end
	end

	// Jump condition against current ALU flags
	always_comb begin
		case (jump)
			jmpNever:  condMet = 1'b0;
			jmpGt:     condMet = !zr && !ng;
			jmpEq:     condMet = zr;
			jmpGe:     condMet = !ng;
			jmpLt:     condMet = ng;
			jmpNe:     condMet = !zr;
			jmpLe:     condMet = zr || ng;
			jmpAlways: condMet = 1'b1;
		endcase
	end

	assign takeJump = isC && condMet; // A-instr never jumps

endmodule
`default_nettype wire

/* source/hackRegisters.sv */
/*
 * CPU state: A, D and PC registers
 * PC increments or loads A on a taken jump
 */
`timescale 1ns/100ps
`default_nettype none
module hackRegisters import hackPkg::*; (
	input  wire     clk,
	input  logic    reset,       // sync, active high
	input  hackWord instruction, // @value source
	input  hackWord aluResult,
	input  logic    loadA,
	input  logic    loadD,
	input  logic    selAFromAlu, // 1 = A from ALU
	input  logic    takeJump,
	output hackWord aRegister,   // also addressM
	output hackWord dRegister,
	output hackWord pc           // next instruction address
);

	hackWord aNext; // A load source

	assign aNext = selAFromAlu ? aluResult : instruction;

	// A and D
	always_ff @(posedge clk) begin
		if (reset) begin
			aRegister <= '0;
			dRegister <= '0;
		end else begin
			if (loadA)
				aRegister <= aNext;
			if (loadD)
				dRegister <= aluResult; // D=comp
		end
	end

	// PC, jump target is A before this edge
	always_ff @(posedge clk) begin
		if (reset)
			pc <= '0; // restart at 0
		else if (takeJump)
			pc <= aRegister;
		else
			pc <= pc + 16'd1;
	end

endmodule
`default_nettype wire

/* source/hackMemoryMap.sv */
/*
 * Data memory map: RAM (0-3583), LED (4096), BUT (4097),
 * DEBUG (4107), address decode and inM read mux
 */
`timescale 1ns/100ps
`default_nettype none
module hackMemoryMap import hackPkg::*; (
	input  wire        clk,
	input  logic       reset,
	input  hackWord    address,  // A register
	input  hackWord    outM,     // ALU result
	input  logic       writeM,
	input  logic [1:0] buttons,  // raw pins
	output hackWord    inM,      // combinational read
	output logic [1:0] leds,
	output hackWord    debugOut
);

	hackWord    ram [ramWords]; // 3584 x 16
	logic [1:0] ledReg;         // low 2 bits of LED word
	logic [1:0] butReg;         // sampled every cycle
	hackWord    debugReg;
	logic       isRam;
	logic       isLed;
	logic       isBut;
	logic       isDebug;

	// Address decode
	assign isRam   = (address < hackWord'(ramWords));
	assign isLed   = (address == ledAddr);
	assign isBut   = (address == butAddr);
	assign isDebug = (address == debugAddr);

	// RAM write, no reset on contents
	always_ff @(posedge clk) begin
		if (writeM && isRam)
			ram[address[ramAddrBits-1:0]] <= outM;
	end

	// IO registers
	always_ff @(posedge clk) begin
		if (reset) begin
			ledReg   <= '0;
			butReg   <= '0;
			debugReg <= '0;
		end else begin
			butReg <= buttons; // read returns last edge's sample
			if (writeM && isLed)
				ledReg <= outM[1:0];
			if (writeM && isDebug)
				debugReg <= outM;
		end
	end

	// Read mux, unmapped reads give 0
	always_comb begin
		if (isRam)
			inM = ram[address[ramAddrBits-1:0]];
		else if (isLed)
			inM = {14'd0, ledReg};
		else if (isBut)
			inM = {14'd0, butReg};
		else if (isDebug)
			inM = debugReg;
		else
			inM = '0;
	end

	assign leds     = ledReg;
	assign debugOut = debugReg;

endmodule
`default_nettype wire

/* source/hackProgramMemory.sv */
/*
 * Instruction memory, 256 words
 * Loaded from outside while held in reset, async read at pc
 */
`timescale 1ns/100ps
`default_nettype none
module hackProgramMemory import hackPkg::*; (
	input  wire                     clk,
	input  logic                    reset,      // write window
	input  hackWord                 pc,
	input  logic                    progWrite,  // level strobe
	input  logic [progAddrBits-1:0] progAddr,
	input  hackWord                 progData,
	output hackWord                 instruction
);

	hackWord mem [progWords]; // program image

	// Loader port, ignored while running
	always_ff @(posedge clk) begin
		if (reset && progWrite)
			mem[progAddr] <= progData;
	end

	// PC wraps within 256 words
	assign instruction = mem[pc[progAddrBits-1:0]];

endmodule
`default_nettype wire

/* source/hackComputer.sv */
/*
 * HACK computer top level: control, ALU, registers,
 * instruction memory and memory-mapped RAM/IO
 */
`timescale 1ns/100ps
`default_nettype none
module hackComputer import hackPkg::*; (
	input  wire                     clk,
	input  logic                    reset,     // sync, active high
	input  logic [1:0]              buttons,   // BUT (4097)
	input  logic                    progWrite, // only while reset
	input  logic [progAddrBits-1:0] progAddr,
	input  hackWord                 progData,
	output logic [1:0]              leds,      // LED (4096)
	output hackWord                 debugOut   // DEBUG (4107)
);

	hackWord instruction, aluResult, aluY, inM;
	hackWord aRegister, dRegister, pc;
	logic    loadA, loadD, selAFromAlu, selYFromM, writeM, takeJump;
	logic    zx, nx, zy, ny, f, no, zr, ng;

	assign aluY = selYFromM ? inM : aRegister; // A or M operand

	hackControl i_control (
		.instruction(instruction), .zr(zr), .ng(ng),
		.loadA(loadA), .loadD(loadD),
		.selAFromAlu(selAFromAlu), .selYFromM(selYFromM),
		.zx(zx), .nx(nx), .zy(zy), .ny(ny), .f(f), .no(no),
		.writeM(writeM), .takeJump(takeJump)
	);

	hackAlu i_alu (
		.x(dRegister), .y(aluY),
		.zx(zx), .nx(nx), .zy(zy), .ny(ny), .f(f), .no(no),
		.result(aluResult), .zr(zr), .ng(ng) // result is also outM
	);

	hackRegisters i_registers (
		.clk(clk), .reset(reset),
		.instruction(instruction), .aluResult(aluResult),
		.loadA(loadA), .loadD(loadD),
		.selAFromAlu(selAFromAlu), .takeJump(takeJump),
		.aRegister(aRegister), .dRegister(dRegister), .pc(pc)
	);

	// A register doubles as addressM
	hackMemoryMap i_memoryMap (
		.clk(clk), .reset(reset),
		.address(aRegister), .outM(aluResult), .writeM(writeM),
		.buttons(buttons),
		.inM(inM), .leds(leds), .debugOut(debugOut)
	);

	hackProgramMemory i_programMemory (
		.clk(clk), .reset(reset), .pc(pc),
		.progWrite(progWrite), .progAddr(progAddr), .progData(progData),
		.instruction(instruction)
	);

endmodule
`default_nettype wire

/* verif/hackComputer_asserts.sv */
/*
 * Concurrent checks on the HACK decoder outputs,
 * bound into hackControl
 */
`timescale 1ns/100ps
`default_nettype none
module hackControlAsserts import hackPkg::*; (
	input wire     clk,
	input hackWord instruction,
	input logic    loadA,
	input logic    selAFromAlu,
	input logic    writeM,
	input logic    takeJump
);

	int unsigned failCount = 0; // summed into the final count

	noWriteOnA: assert property (@(posedge clk) !instruction[instrMsb] |-> !writeM)
		else begin
			failCount++;
			$error("writeM set during an A-instruction");
		end

	// @value must load A from the instruction word
	aLoadSource: assert property (@(posedge clk)
			(!instruction[instrMsb] && loadA) |-> !selAFromAlu)
		else begin
			failCount++;
			$error("A-instruction loads A from the ALU");
		end

	neverNoJump: assert property (@(posedge clk)
			(jumpCond'(instruction[jumpMsb:jumpLsb]) == jmpNever) |-> !takeJump)
		else begin
			failCount++;
			$error("Jump taken with the never condition");
		end

endmodule
`default_nettype wire

/* verif/hackComputerTb.sv */
/*
 * Testbench for the HACK computer: loads short programs in reset,
 * checks ALU results, M operands, jumps, button/LED IO and restart
 */
`timescale 1ns/100ps
`default_nettype none
module hackComputerTb import hackPkg::*; ();

	logic                    clk = 1'b0;
	logic                    reset;
	logic [1:0]              buttons;
	logic                    progWrite;
	logic [progAddrBits-1:0] progAddr;
	hackWord                 progData;
	logic [1:0]              leds;
	hackWord                 debugOut;

	hackWord     xTab[$], yTab[$]; // stimulus table columns
	compCode     compTab[$];
	jumpCond     jumpTab[$];
	logic [1:0]  butTab[$] = '{2'b01, 2'b11, 2'b10, 2'b00, 2'b10, 2'b01};
	hackWord     prog [16];         // image for the next load
	hackWord     lastResult, lastFinal;
	logic [31:0] rngState = 32'h9a42a370;
	int unsigned checks = 0, valueErrors = 0, timeouts = 0, assertFails = 0;

	always #50 clk = ~clk; // 100 ns

	hackComputer i_hackComputer (
		.clk(clk), .reset(reset), .buttons(buttons),
		.progWrite(progWrite), .progAddr(progAddr), .progData(progData),
		.leds(leds), .debugOut(debugOut)
	);

	bind hackControl hackControlAsserts i_controlAsserts (
		.clk(hackComputerTb.clk), .instruction(instruction), .loadA(loadA),
		.selAFromAlu(selAFromAlu), .writeM(writeM), .takeJump(takeJump)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] r;
		r = s ^ (s << 13);
		r = r ^ (r >> 17);
		return r ^ (r << 5);
	endfunction

	function automatic hackWord aInstr(input hackWord value);
		return {1'b0, value[14:0]}; // @value
	endfunction

	// 111 a c1..c6 d1d2d3 j1j2j3
	function automatic hackWord cInstr(input compCode comp, input logic [2:0] dest,
			input jumpCond jump);
		return {3'b111, comp, dest, jump};
	endfunction

	// Reference ALU chain: zero, negate, add/and, negate out
	function automatic hackWord aluModel(input hackWord x, input hackWord y, input compCode comp);
		logic [6:0] c;
		hackWord    xs, ys, out;
		c  = comp;
		xs = c[5] ? 16'h0000 : x;
		xs = c[4] ? ~xs : xs;
		ys = c[3] ? 16'h0000 : y;
		ys = c[2] ? ~ys : ys;
		out = c[1] ? xs + ys : xs & ys;
		return c[0] ? ~out : out;
	endfunction

	// Jump decision from the signed value itself
	function automatic logic jumpModel(input hackWord v, input jumpCond j);
		logic signed [15:0] s;
		s = v;
		case (j)
			jmpGt:     return s > 0;
			jmpEq:     return s == 0;
			jmpGe:     return s >= 0;
			jmpLt:     return s < 0;
			jmpNe:     return s != 0;
			jmpLe:     return s <= 0;
			jmpAlways: return 1'b1;
			default:   return 1'b0; // never
		endcase
	endfunction

	function automatic void addRow(input hackWord x, input hackWord y, input compCode comp,
			input jumpCond jump);
		xTab.push_back(x & 16'h7fff); // @ loads 15 bits only
		yTab.push_back(y & 16'h7fff);
		compTab.push_back(comp);
		jumpTab.push_back(jump);
	endfunction

	task automatic checkWord(input string name, input hackWord actual, input hackWord expected);
		checks++;
		if (actual !== expected) begin
			valueErrors++;
			$display("ERROR t=%0t %s: got %h expected %h", $time, name, actual, expected);
		end
	endtask

	task automatic checkLeds(input string name, input logic [1:0] actual,
			input logic [1:0] expected);
		checks++;
		if (actual !== expected) begin
			valueErrors++;
			$display("ERROR t=%0t %s: got %b expected %b", $time, name, actual, expected);
		end
	endtask

	// n rising edges, then sample at the falling edge
	task automatic runCycles(input int n);
		for (int i = 0; i < n; i++)
			@(posedge clk);
		@(negedge clk);
	endtask

	task automatic holdReset();
		@(posedge clk);
		reset <= 1'b1;
		runCycles(5);
		checkLeds("leds", leds, 2'b00); // IO cleared by reset
		checkWord("debugOut", debugOut, 16'h0000);
	endtask

	// Last write lands on the release edge
	task automatic releaseReset();
		@(posedge clk);
		progWrite <= 1'b0;
		reset     <= 1'b0;
	endtask

	task automatic loadProgram(input int n);
		for (int i = 0; i < n; i++) begin
			@(posedge clk);
			progWrite <= 1'b1;
			progAddr  <= progAddrBits'(i);
			progData  <= prog[i];
		end
		releaseReset();
	endtask

	task automatic runRow(input hackWord x, input hackWord y, input compCode comp,
			input jumpCond jump);
		logic [6:0] compBits;
		compBits = comp;
		prog[0]  = aInstr(y);
		prog[1]  = cInstr(compA, 3'b010, jmpNever);      // D=A
		prog[2]  = aInstr(16'd100);                      // RAM scratch word
		prog[3]  = cInstr(compD, 3'b001, jmpNever);      // M=D
		prog[4]  = aInstr(x);
		prog[5]  = cInstr(compA, 3'b010, jmpNever);
		prog[6]  = aInstr(compBits[6] ? 16'd100 : y);    // M or A operand
		prog[7]  = cInstr(comp, 3'b010, jmpNever);       // D=comp
		prog[8]  = aInstr(debugAddr);
		prog[9]  = cInstr(compD, 3'b001, jmpNever);      // DEBUG=D
		prog[10] = aInstr(16'd14);
		prog[11] = cInstr(compD, 3'b000, jump);          // D;jump
		prog[12] = aInstr(debugAddr);
		prog[13] = cInstr(compDPlus1, 3'b001, jmpNever); // marker
		prog[14] = aInstr(16'd14);
		prog[15] = cInstr(compZero, 3'b000, jmpAlways);  // park
		lastResult = aluModel(x, y, comp);
		lastFinal  = jumpModel(lastResult, jump) ? lastResult : lastResult + 16'd1;
		holdReset();
		loadProgram(16);
		runCycles(10); // instruction 9 done
		checkWord("debugOut", debugOut, lastResult);
		runCycles(6);
		checkWord("debugOut", debugOut, lastFinal);
	endtask

	task automatic runButtons();
		int unsigned waited, limit;
		logic [1:0]  prevLeds; // value before this row
		limit   = 10; // sample edge + 6-word loop + margin
		prog[0] = aInstr(butAddr);
		prog[1] = cInstr(compM, 3'b010, jmpNever); // D=BUT
		prog[2] = aInstr(ledAddr);
		prog[3] = cInstr(compD, 3'b001, jmpNever); // LED=D
		prog[4] = aInstr(16'd0);
		prog[5] = cInstr(compZero, 3'b000, jmpAlways);
		holdReset();
		loadProgram(6);
		prevLeds = 2'b00; // reset value
		foreach (butTab[i]) begin
			@(posedge clk);
			buttons <= butTab[i];
			waited = 0;
			@(negedge clk);
			// Neighbouring table values differ, so leds must move
			while (leds === prevLeds && waited < limit) begin
				@(negedge clk);
				waited++;
			end
			if (leds === prevLeds) begin
				timeouts++;
				$display("Timeout: leds did not follow buttons %b within %0d cycles",
					butTab[i], limit);
			end else
				checkLeds("leds", leds, butTab[i]);
			prevLeds = butTab[i];
		end
	endtask

	task automatic buildTable();
		compCode c;
		addRow(16'd0, 16'd0, compZero, jmpEq);
		addRow(16'd7, 16'd3, compOne, jmpGt);
		addRow(16'd7, 16'd3, compMinusOne, jmpLt);      // constant -1
		addRow(16'd1234, 16'd1234, compDMinusA, jmpEq); // zero result
		addRow(16'd5, 16'd9, compDMinusM, jmpLe);       // negative via M
		addRow(16'h7fff, 16'd1, compDPlusA, jmpNe);     // wraps to 8000
		c = c.first();
		for (int i = 0; i < c.num(); i++) begin // every comp, jumps cycled
			rngState = xorshift(rngState);
			addRow(rngState[15:0], rngState[31:16], c, jumpCond'(i % 8));
			c = c.next();
		end
	endtask

	initial begin
		reset     <= 1'b1;
		buttons   <= 2'b00;
		progWrite <= 1'b0;
		progAddr  <= '0;
		progData  <= '0;
		buildTable();
		foreach (xTab[i])
			runRow(xTab[i], yTab[i], compTab[i], jumpTab[i]);
		// Same image again, must restart from address 0
		holdReset();
		releaseReset();
		runCycles(10);
		checkWord("debugOut", debugOut, lastResult);
		runCycles(6);
		checkWord("debugOut", debugOut, lastFinal);
		runButtons();
		holdReset();
		assertFails = i_hackComputer.i_control.i_controlAsserts.failCount;
		$display("Checks %0d, value errors %0d, timeouts %0d, assertion failures %0d",
			checks, valueErrors, timeouts, assertFails);
		if (valueErrors + timeouts + assertFails == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule
`default_nettype wire

/* sources.f */
source/hackPkg.sv
source/hackAlu.sv
source/hackControl.sv
source/hackRegisters.sv
source/hackMemoryMap.sv
source/hackProgramMemory.sv
source/hackComputer.sv
verif/hackComputer_asserts.sv
verif/hackComputerTb.sv

/* Bender.yml */
package:
  name: hack_computer

sources:
  - source/hackPkg.sv
  - source/hackAlu.sv
  - source/hackControl.sv
  - source/hackRegisters.sv
  - source/hackMemoryMap.sv
  - source/hackProgramMemory.sv
  - source/hackComputer.sv
  - target: test
    files:
      - verif/hackComputer_asserts.sv
      - verif/hackComputerTb.sv
